//--- Makefile
all: run

obj_dir/Vtb_branch_predictor: all.f hdl/*.sv tb/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module tb_branch_predictor -f all.f

run: obj_dir/Vtb_branch_predictor tb/bp_input.txt
	./obj_dir/Vtb_branch_predictor > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Checks failed" sim.log; then exit 1; fi
	@grep -q "All checks passed" sim.log

lint:
	verilator --lint-only --timing -Wall -Wno-fatal --top-module branch_predictor -f all.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

//--- all.f
hdl/bp_pkg.sv
hdl/branch_target_buffer.sv
hdl/local_history_predictor.sv
hdl/gshare_predictor.sv
hdl/tournament_chooser.sv
hdl/branch_predictor.sv
tb/prediction_checker.sv
tb/tb_branch_predictor.sv

//--- hdl/bp_pkg.sv
package bp_pkg;

    localparam int fetch_width      = 2;
    localparam int table_index_bits = 4;
    localparam int table_entries    = 16;
    localparam int history_bits     = 4;
    localparam int offset_bits      = 2;
    localparam int tag_bits         = 32 - table_index_bits - offset_bits;

    typedef logic [31:0] addr_t;

    // tag, table index and word offset of one fetch address
    typedef struct packed {
        logic [tag_bits-1:0]         tag;
        logic [table_index_bits-1:0] index;
        logic [offset_bits-1:0]      offset;
    } pc_fields_t;

    typedef union packed {
        addr_t      raw;
        pc_fields_t fields;
    } pc_fields_u;

    typedef enum logic {
        not_taken = 1'b0,
        taken     = 1'b1
    } direction_e;

    // one retired branch from the reorder buffer
    typedef struct packed {
        logic       valid;
        addr_t      pc;
        direction_e taken;
        addr_t      target;
    } resolve_entry_t;

    typedef resolve_entry_t [fetch_width-1:0] resolve_packet_t;

    // pc is the predicted next fetch address after this slot
    typedef struct packed {
        logic  valid;
        logic  taken;
        addr_t pc;
    } slot_prediction_t;

    typedef slot_prediction_t [fetch_width-1:0] fetch_prediction_t;

    typedef addr_t [fetch_width-1:0] slot_pcs_t;

endpackage

//--- hdl/branch_predictor.sv
module branch_predictor (
    input  logic                      clock,
    input  logic                      reset,
    input  bp_pkg::addr_t             pc_start,
    input  bp_pkg::resolve_packet_t   resolve,
    output bp_pkg::fetch_prediction_t prediction
);

    bp_pkg::slot_pcs_t                            slot_pcs;
    logic [bp_pkg::fetch_width-1:0]               btb_hit;
    bp_pkg::slot_pcs_t                            btb_target;
    bp_pkg::direction_e [bp_pkg::fetch_width-1:0] local_dir;
    bp_pkg::direction_e [bp_pkg::fetch_width-1:0] global_dir;
    logic [bp_pkg::fetch_width-1:0]               local_correct;
    logic [bp_pkg::fetch_width-1:0]               global_correct;

    tournament_chooser chooser (
        .clock          (clock),
        .reset          (reset),
        .pc_start       (pc_start),
        .local_dir      (local_dir),
        .global_dir     (global_dir),
        .local_correct  (local_correct),
        .global_correct (global_correct),
        .btb_hit        (btb_hit),
        .btb_target     (btb_target),
        .resolve        (resolve),
        .slot_pcs       (slot_pcs),
        .prediction     (prediction)
    );

    branch_target_buffer btb (
        .clock      (clock),
        .reset      (reset),
        .slot_pcs   (slot_pcs),
        .resolve    (resolve),
        .btb_hit    (btb_hit),
        .btb_target (btb_target)
    );

    local_history_predictor local_pred (
        .clock         (clock),
        .reset         (reset),
        .slot_pcs      (slot_pcs),
        .resolve       (resolve),
        .local_dir     (local_dir),
        .local_correct (local_correct)
    );

    gshare_predictor gshare_pred (
        .clock          (clock),
        .reset          (reset),
        .slot_pcs       (slot_pcs),
        .resolve        (resolve),
        .global_dir     (global_dir),
        .global_correct (global_correct)
    );

endmodule

//--- hdl/branch_target_buffer.sv
module branch_target_buffer (
    input  logic                                clock,
    input  logic                                reset,
    input  bp_pkg::slot_pcs_t                   slot_pcs,
    input  bp_pkg::resolve_packet_t             resolve,
    output logic [bp_pkg::fetch_width-1:0]      btb_hit,
    output bp_pkg::slot_pcs_t                   btb_target
);

    typedef struct packed {
        logic [bp_pkg::tag_bits-1:0] tag;
        bp_pkg::addr_t               target;
    } btb_payload_t;

    logic [bp_pkg::table_entries-1:0]         entry_valid, entry_valid_next;
    btb_payload_t [bp_pkg::table_entries-1:0] payload, payload_next;

    for (genvar i = 0; i < bp_pkg::fetch_width; i++) begin : g_lookup
        bp_pkg::pc_fields_u lookup_pc;

        assign lookup_pc.raw = slot_pcs[i];
        assign btb_hit[i]    = entry_valid[lookup_pc.fields.index]
                            && (payload[lookup_pc.fields.index].tag == lookup_pc.fields.tag);
        assign btb_target[i] = payload[lookup_pc.fields.index].target;
    end

    // later slot overwrites an earlier one at the same index
    always_comb begin
        bp_pkg::pc_fields_u write_pc;

        entry_valid_next = entry_valid;
        payload_next     = payload;
        for (int i = 0; i < bp_pkg::fetch_width; i++) begin
            write_pc.raw = resolve[i].pc;
            if (resolve[i].valid && resolve[i].taken == bp_pkg::taken) begin
                entry_valid_next[write_pc.fields.index]  = 1'b1;
                payload_next[write_pc.fields.index].tag    = write_pc.fields.tag;
                payload_next[write_pc.fields.index].target = resolve[i].target;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
        end else begin
            entry_valid <= entry_valid_next;
        end
    end

    always_ff @(posedge clock) begin
        payload <= payload_next;
    end

    // table comes out of reset empty
    a_no_hit_after_reset: assert property (
        @(posedge clock) $fell(reset) |-> (btb_hit == '0)
    );

endmodule

//--- hdl/gshare_predictor.sv
module gshare_predictor (
    input  logic                                        clock,
    input  logic                                        reset,
    input  bp_pkg::slot_pcs_t                           slot_pcs,
    input  bp_pkg::resolve_packet_t                     resolve,
    output bp_pkg::direction_e [bp_pkg::fetch_width-1:0] global_dir,
    output logic [bp_pkg::fetch_width-1:0]              global_correct
);

    logic [bp_pkg::history_bits-1:0]                global_history, global_history_next;
    bp_pkg::direction_e [bp_pkg::table_entries-1:0] pattern, pattern_next;

    for (genvar i = 0; i < bp_pkg::fetch_width; i++) begin : g_lookup
        bp_pkg::pc_fields_u lookup_pc;

        assign lookup_pc.raw = slot_pcs[i];
        assign global_dir[i] = pattern[global_history ^ lookup_pc.fields.index];
    end

    always_comb begin
        bp_pkg::pc_fields_u                  resolve_pc;
        logic [bp_pkg::table_index_bits-1:0] pattern_index;

        global_history_next = global_history;
        pattern_next        = pattern;
        global_correct      = '0;
        for (int i = 0; i < bp_pkg::fetch_width; i++) begin
            resolve_pc.raw = resolve[i].pc;
            pattern_index  = global_history ^ resolve_pc.fields.index;
            if (resolve[i].valid) begin
                // one shift per retired branch, in slot order
                global_history_next = {
                    global_history_next[bp_pkg::history_bits-2:0],
                    resolve[i].taken
                };
                pattern_next[pattern_index] = resolve[i].taken;
                global_correct[i]           = (pattern[pattern_index] == resolve[i].taken);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            global_history <= '0;
            pattern        <= {bp_pkg::table_entries{bp_pkg::not_taken}};
        end else begin
            global_history <= global_history_next;
            pattern        <= pattern_next;
        end
    end

    for (genvar i = 0; i < bp_pkg::fetch_width; i++) begin : g_check
        a_correct_needs_valid: assert property (
            @(posedge clock) disable iff (reset)
            !resolve[i].valid |-> !global_correct[i]
        );
    end

endmodule

//--- hdl/local_history_predictor.sv
module local_history_predictor (
    input  logic                                        clock,
    input  logic                                        reset,
    input  bp_pkg::slot_pcs_t                           slot_pcs,
    input  bp_pkg::resolve_packet_t                     resolve,
    output bp_pkg::direction_e [bp_pkg::fetch_width-1:0] local_dir,
    output logic [bp_pkg::fetch_width-1:0]              local_correct
);

    // per-address history, one entry per table index
    logic [bp_pkg::table_entries-1:0][bp_pkg::history_bits-1:0] history, history_next;

    // pattern table, indexed by a history value
    bp_pkg::direction_e [bp_pkg::table_entries-1:0] pattern, pattern_next;

    for (genvar i = 0; i < bp_pkg::fetch_width; i++) begin : g_lookup
        bp_pkg::pc_fields_u lookup_pc;

        assign lookup_pc.raw = slot_pcs[i];
        assign local_dir[i]  = pattern[history[lookup_pc.fields.index]];
    end

    always_comb begin
        bp_pkg::pc_fields_u              resolve_pc;
        logic [bp_pkg::history_bits-1:0] start_history;

        history_next  = history;
        pattern_next  = pattern;
        local_correct = '0;
        for (int i = 0; i < bp_pkg::fetch_width; i++) begin
            resolve_pc.raw = resolve[i].pc;
            // pattern slot is chosen by the history as it stood at the clock edge
            start_history  = history[resolve_pc.fields.index];
            if (resolve[i].valid) begin
                history_next[resolve_pc.fields.index] = {
                    history_next[resolve_pc.fields.index][bp_pkg::history_bits-2:0],
                    resolve[i].taken
                };
                pattern_next[start_history] = resolve[i].taken;
                local_correct[i]            = (pattern[start_history] == resolve[i].taken);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            history <= '0;
            // odd pattern entries start out taken
            for (int k = 0; k < bp_pkg::table_entries; k++) begin
                pattern[k] <= bp_pkg::direction_e'(k[0]);
            end
        end else begin
            history <= history_next;
            pattern <= pattern_next;
        end
    end

endmodule

//--- hdl/tournament_chooser.sv
module tournament_chooser (
    input  logic                                        clock,
    input  logic                                        reset,
    input  bp_pkg::addr_t                               pc_start,
    input  bp_pkg::direction_e [bp_pkg::fetch_width-1:0] local_dir,
    input  bp_pkg::direction_e [bp_pkg::fetch_width-1:0] global_dir,
    input  logic [bp_pkg::fetch_width-1:0]              local_correct,
    input  logic [bp_pkg::fetch_width-1:0]              global_correct,
    input  logic [bp_pkg::fetch_width-1:0]              btb_hit,
    input  bp_pkg::slot_pcs_t                           btb_target,
    input  bp_pkg::resolve_packet_t                     resolve,
    output bp_pkg::slot_pcs_t                           slot_pcs,
    output bp_pkg::fetch_prediction_t                   prediction
);

    // nonzero picks the local predictor
    logic [1:0] choice, choice_next;

    for (genvar i = 0; i < bp_pkg::fetch_width; i++) begin : g_slot
        bp_pkg::direction_e chosen_dir;

        if (i == 0) begin : g_first
            assign slot_pcs[i] = pc_start;
        end else begin : g_chain
            assign slot_pcs[i] = prediction[i-1].pc;
        end

        assign chosen_dir          = (choice != 2'd0) ? local_dir[i] : global_dir[i];
        assign prediction[i].valid = 1'b1;
        assign prediction[i].taken = (chosen_dir == bp_pkg::taken) && btb_hit[i];
        assign prediction[i].pc    = prediction[i].taken ? btb_target[i] : slot_pcs[i] + 32'd4;
    end

    always_comb begin
        choice_next = choice;
        for (int i = 0; i < bp_pkg::fetch_width; i++) begin
            if (resolve[i].valid) begin
                if (local_correct[i] && !global_correct[i] && choice_next != 2'd3) begin
                    choice_next = choice_next + 2'd1;
                end else if (global_correct[i] && !local_correct[i] && choice_next != 2'd0) begin
                    choice_next = choice_next - 2'd1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            choice <= 2'd3;
        end else begin
            choice <= choice_next;
        end
    end

    for (genvar i = 0; i < bp_pkg::fetch_width - 1; i++) begin : g_check
        a_fall_through_chain: assert property (
            @(posedge clock) disable iff (reset)
            !prediction[i].taken |-> (slot_pcs[i+1] == slot_pcs[i] + 32'd4)
        );
    end

endmodule

//--- tb/bp_input.txt
# name start | r0: valid pc taken target | r1: valid pc taken target
# | expected slot0: taken next_pc | expected slot1: taken next_pc  (hex)
reset_idle       00001000 0 00000000 0 00000000 0 00000000 0 00000000 0 00001004 0 00001008
train_taken      00002000 1 00001010 1 00003000 0 00000000 0 00000000 0 00002004 0 00002008
local_taken      00001010 0 00000000 0 00000000 0 00000000 0 00000000 1 00003000 0 00003004
alias_miss       00002010 0 00000000 0 00000000 0 00000000 0 00000000 0 00002014 0 00002018
train_global_a   00001000 1 00001008 0 00000000 1 00001008 0 00000000 0 00001004 0 00001008
train_global_b   00001010 1 00001000 1 00005000 0 00000000 0 00000000 1 00003000 0 00003004
global_chosen    00001010 0 00000000 0 00000000 0 00000000 0 00000000 0 00001014 0 00001018
dual_clash       00001000 1 00002010 1 00006000 1 00001010 1 00007000 0 00001004 0 00001008
clash_winner     00001010 1 00001020 1 00008000 1 00001024 0 00000000 1 00007000 0 00007004
mixed_order      00001020 1 00001028 1 00009000 1 0000100c 1 0000a000 1 00008000 0 00008004
global_order     00001010 0 00000000 0 00000000 0 00000000 0 00000000 1 00007000 0 00007004
loop_train       00001020 1 00001000 1 00005000 1 00001010 1 00001010 0 00001024 0 00001028
loop_chain       00001010 0 00000000 0 00000000 0 00000000 0 00000000 1 00001010 1 00001010
alias_taken_dir  00002010 0 00000000 0 00000000 0 00000000 0 00000000 0 00002014 0 00002018

//--- tb/prediction_checker.sv
module prediction_checker #(
    parameter int sample_delay = 9
) (
    input  logic                      clock,
    input  bp_pkg::addr_t             pc_start,
    input  bp_pkg::resolve_packet_t   resolve,
    input  bp_pkg::fetch_prediction_t prediction,
    input  logic                      check_valid,
    input  logic [127:0]              test_name,
    input  bp_pkg::fetch_prediction_t expected,
    input  logic                      file_error,
    output int                        pass_count,
    output int                        fail_count
);

    logic file_error_reported;

    function automatic int count_resolves(bp_pkg::resolve_packet_t packet);
        int total;

        total = 0;
        for (int i = 0; i < bp_pkg::fetch_width; i++) begin
            if (packet[i].valid) begin
                total++;
            end
        end
        return total;
    endfunction

    function automatic string describe(bp_pkg::fetch_prediction_t slots);
        string text;

        text = "";
        for (int i = 0; i < bp_pkg::fetch_width; i++) begin
            text = {text, $sformatf(" [v=%0b t=%0b pc=%h]",
                                    slots[i].valid, slots[i].taken, slots[i].pc)};
        end
        return text;
    endfunction

    initial begin
        pass_count          = 0;
        fail_count          = 0;
        file_error_reported = 1'b0;
    end

    // inputs change on the falling edge, so sample late in the low phase
    always @(negedge clock) begin
        #(sample_delay);
        if (file_error && !file_error_reported) begin
            file_error_reported = 1'b1;
            fail_count++;
            $display("The stimulus file ran out before all test lines were read");
        end
        if (check_valid) begin
            if (prediction === expected) begin
                pass_count++;
                $display("PASS %0s (pc_start %h, %0d resolves)",
                         test_name, pc_start, count_resolves(resolve));
            end else begin
                fail_count++;
                $display("FAIL %0s expected%s actual%s",
                         test_name, describe(expected), describe(prediction));
            end
        end
    end

endmodule

//--- tb/tb_branch_predictor.sv
module tb_branch_predictor;

    localparam int clock_period = 20;
    localparam int reset_cycles = 16;

    typedef struct packed {
        logic [127:0]              name;
        bp_pkg::addr_t             pc_start;
        bp_pkg::resolve_packet_t   resolve;
        bp_pkg::fetch_prediction_t expected;
    } test_vector_t;

    logic                      clock;
    logic                      reset;
    bp_pkg::addr_t             pc_start;
    bp_pkg::resolve_packet_t   resolve;
    bp_pkg::fetch_prediction_t prediction;

    test_vector_t tests[$];
    test_vector_t current;
    logic         check_valid;
    logic         file_error;
    int           limit_cycles;
    int           pass_count;
    int           fail_count;

    branch_predictor dut (
        .clock      (clock),
        .reset      (reset),
        .pc_start   (pc_start),
        .resolve    (resolve),
        .prediction (prediction)
    );

    prediction_checker #(
        .sample_delay (clock_period / 2 - 1)
    ) pred_check (
        .clock       (clock),
        .pc_start    (pc_start),
        .resolve     (resolve),
        .prediction  (prediction),
        .check_valid (check_valid),
        .test_name   (current.name),
        .expected    (current.expected),
        .file_error  (file_error),
        .pass_count  (pass_count),
        .fail_count  (fail_count)
    );

    task automatic load_tests();
        int           fd;
        int           fields;
        string        line;
        logic [127:0] name;
        logic [31:0]  value [13];
        test_vector_t vec;

        fd = $fopen("tb/bp_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open tb/bp_input.txt");
            file_error = 1'b1;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            // column notes and blank lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
                             value[0], value[1], value[2], value[3], value[4], value[5],
                             value[6], value[7], value[8], value[9], value[10], value[11],
                             value[12]);
            if (fields != 14) begin
                file_error = 1'b1;
                break;
            end
            vec.name     = name;
            vec.pc_start = value[0];
            for (int i = 0; i < bp_pkg::fetch_width; i++) begin
                vec.resolve[i].valid    = value[1 + 4 * i][0];
                vec.resolve[i].pc       = value[2 + 4 * i];
                vec.resolve[i].taken    = bp_pkg::direction_e'(value[3 + 4 * i][0]);
                vec.resolve[i].target   = value[4 + 4 * i];
                vec.expected[i].valid   = 1'b1;
                vec.expected[i].taken   = value[9 + 2 * i][0];
                vec.expected[i].pc      = value[10 + 2 * i];
            end
            tests.push_back(vec);
        end
        $fclose(fd);
        if (tests.size() == 0) begin
            file_error = 1'b1;
        end
    endtask

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clock);
        $display("Run timed out after %0d clock cycles", limit_cycles);
        $display("Checks failed");
        $finish;
    end

    initial begin
        reset        = 1'b1;
        pc_start     = '0;
        resolve      = '0;
        check_valid  = 1'b0;
        current      = '0;
        file_error   = 1'b0;
        load_tests();
        limit_cycles = 20 * tests.size() + reset_cycles + 100;
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        // one test per cycle, resolve takes effect at the next rising edge
        foreach (tests[i]) begin
            current     = tests[i];
            pc_start    = tests[i].pc_start;
            resolve     = tests[i].resolve;
            check_valid = 1'b1;
            @(negedge clock);
        end
        check_valid = 1'b0;
        resolve     = '0;
        $display("Tests run: %0d, passed: %0d, failed: %0d",
                 tests.size(), pass_count, fail_count);
        if (fail_count == 0 && pass_count == tests.size() && !file_error) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
